/* include/ntm_vector_defines.svh */
`ifndef NTM_VECTOR_DEFINES_SVH
`define NTM_VECTOR_DEFINES_SVH

// Operand, modulus and result width
`define NTM_DATA_WIDTH 16
// Row count and row length counters
`define NTM_COUNT_WIDTH 8
// Result buffer pointer width, depth is a power of two
`define NTM_FIFO_ADDR_WIDTH 2

// Result beat order, msb first: data, row_end, last
`endif

/* design/ntm_vector_pkg.sv */
`include "ntm_vector_defines.svh"

package ntm_vector_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH      = `NTM_DATA_WIDTH;
  localparam int COUNT_WIDTH     = `NTM_COUNT_WIDTH;
  localparam int FIFO_ADDR_WIDTH = `NTM_FIFO_ADDR_WIDTH;
  localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;

  // Multiplier step counter, one step per bit of b
  localparam int STEP_WIDTH = $clog2(DATA_WIDTH);
  localparam logic [STEP_WIDTH-1:0] LAST_STEP = STEP_WIDTH'(DATA_WIDTH - 1);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Controller, outer loop over rows and inner loop over scalars
  typedef enum logic [2:0] {
    STARTER      = 3'd0,
    INPUT_VECTOR = 3'd1,
    INPUT_SCALAR = 3'd2,
    MULTIPLY     = 3'd3,
    ENDER        = 3'd4
  } ctrl_state_t;

  // Iterative multiplier
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } mult_state_t;

  // Job configuration
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  modulo;
    logic [COUNT_WIDTH-1:0] size;
    logic [COUNT_WIDTH-1:0] length;
  } mult_config_t;

  // One result entry
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  row_end;
    logic                  last;
  } mult_result_t;

endpackage

/* design/ntm_scalar_multiplication.sv */
`timescale 1ns/1ns

module ntm_scalar_multiplication (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_vector_pkg::DATA_WIDTH-1:0] a,
  input  logic [ntm_vector_pkg::DATA_WIDTH-1:0] b,
  input  logic [ntm_vector_pkg::DATA_WIDTH-1:0] modulo,
  output logic                              done,
  output logic [ntm_vector_pkg::DATA_WIDTH-1:0] product
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_vector_pkg::mult_state_t state;
  logic [ntm_vector_pkg::STEP_WIDTH-1:0] step;

  // Latched operands, b shifts left one bit per step
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] a_q;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] b_q;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] m_q;

  // Two spare bits, partial value stays below 3 times the modulus
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] acc;
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] acc_dbl;
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] acc_sum;
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] acc_sub;
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] acc_next;
  logic [ntm_vector_pkg::DATA_WIDTH+1:0] m_ext;

  ////////////////////////////////////////////////////////////
  // One shift-and-add step
  ////////////////////////////////////////////////////////////

  always_comb begin
    m_ext   = {2'b00, m_q};
    acc_dbl = {acc[ntm_vector_pkg::DATA_WIDTH:0], 1'b0};
    // Add a when the current msb of b is set
    acc_sum = b_q[ntm_vector_pkg::DATA_WIDTH-1] ? acc_dbl + {2'b00, a_q} : acc_dbl;
    // Up to two subtractions bring it back below m
    acc_sub  = (acc_sum >= m_ext) ? acc_sum - m_ext : acc_sum;
    acc_next = (acc_sub >= m_ext) ? acc_sub - m_ext : acc_sub;
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_vector_pkg::IDLE;
      step  <= '0;
    end else begin
      case (state)
        ntm_vector_pkg::IDLE: begin
          if (start) begin
            step  <= '0;
            state <= ntm_vector_pkg::RUN;
          end
        end
        ntm_vector_pkg::RUN: begin
          step <= step + 1'b1;
          // DATA_WIDTH steps, then hold the product one cycle
          if (step == ntm_vector_pkg::LAST_STEP) begin
            state <= ntm_vector_pkg::DONE;
          end
        end
        ntm_vector_pkg::DONE: begin
          state <= ntm_vector_pkg::IDLE;
        end
        default: begin
          state <= ntm_vector_pkg::IDLE;
        end
      endcase
    end
  end

  // Operands and accumulator
  always_ff @(posedge CLK) begin
    if (state == ntm_vector_pkg::IDLE && start) begin
      a_q <= a;
      b_q <= b;
      m_q <= modulo;
      acc <= '0;
    end else if (state == ntm_vector_pkg::RUN) begin
      acc <= acc_next;
      b_q <= {b_q[ntm_vector_pkg::DATA_WIDTH-2:0], 1'b0};
    end
  end

  // Result valid for exactly one cycle
  assign done    = (state == ntm_vector_pkg::DONE);
  assign product = acc[ntm_vector_pkg::DATA_WIDTH-1:0];

endmodule

/* design/ntm_result_fifo.sv */
`timescale 1ns/1ns

module ntm_result_fifo (
  input  logic                         CLK,
  input  logic                         RST,
  // Write side
  input  logic                         push,
  input  ntm_vector_pkg::mult_result_t push_result,
  output logic                         full,
  // Read side
  output logic                         out_valid,
  output ntm_vector_pkg::mult_result_t out_result,
  input  logic                         out_ready
);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  ntm_vector_pkg::mult_result_t mem [ntm_vector_pkg::FIFO_DEPTH];

  logic [ntm_vector_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
  logic [ntm_vector_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [ntm_vector_pkg::FIFO_ADDR_WIDTH:0]   count;

  logic pop;

  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  // Depth is a power of two, so the top bit means full
  assign full      = count[ntm_vector_pkg::FIFO_ADDR_WIDTH];
  // Head entry straight from storage
  assign out_result = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Pointer and occupancy update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own width
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push with pop keeps the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Writer checks full before pushing
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_result;
    end
  end

endmodule

/* design/ntm_vector_multiplication.sv */
`timescale 1ns/1ns

module ntm_vector_multiplication (
  input  logic                                  CLK,
  input  logic                                  RST,
  // Job control
  input  logic                                  start,
  input  ntm_vector_pkg::mult_config_t          job_config,
  output logic                                  busy,
  output logic                                  done,
  // Operand stream
  input  logic                                  in_valid,
  input  logic [ntm_vector_pkg::DATA_WIDTH-1:0] in_data,
  output logic                                  in_ready,
  // Result buffer side
  output logic                                  push,
  output ntm_vector_pkg::mult_result_t          push_result,
  input  logic                                  full
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_vector_pkg::ctrl_state_t state;

  // Outer and inner loop indices
  logic [ntm_vector_pkg::COUNT_WIDTH-1:0] vec_idx;
  logic [ntm_vector_pkg::COUNT_WIDTH-1:0] sca_idx;

  ntm_vector_pkg::mult_config_t cfg_q;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] prod_q;

  // Multiplier interface
  logic                                  mul_start;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] mul_a;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] mul_b;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] mul_modulo;
  logic                                  mul_done;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] mul_product;

  logic row_end;
  logic job_end;
  logic beat;

  ////////////////////////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////////////////////////

  assign in_ready = (state == ntm_vector_pkg::INPUT_VECTOR) ||
                    (state == ntm_vector_pkg::INPUT_SCALAR);
  assign beat     = in_valid && in_ready;
  assign busy     = (state != ntm_vector_pkg::STARTER);

  // Loop end flags
  assign row_end = (sca_idx == cfg_q.length - 1'b1);
  assign job_end = row_end && (vec_idx == cfg_q.size - 1'b1);

  // Push only while the buffer has room
  assign push                = (state == ntm_vector_pkg::ENDER) && !full;
  assign push_result.data    = prod_q;
  assign push_result.row_end = row_end;
  assign push_result.last    = job_end;

  assign mul_modulo = cfg_q.modulo;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_vector_pkg::STARTER;
      vec_idx   <= '0;
      sca_idx   <= '0;
      mul_start <= 1'b0;
      done      <= 1'b0;
    end else begin
      // Single cycle strobes
      mul_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        ntm_vector_pkg::STARTER: begin
          if (start) begin
            vec_idx <= '0;
            sca_idx <= '0;
            state   <= ntm_vector_pkg::INPUT_VECTOR;
          end
        end
        ntm_vector_pkg::INPUT_VECTOR: begin
          // First beat of a row is x
          if (beat) begin
            state <= ntm_vector_pkg::INPUT_SCALAR;
          end
        end
        ntm_vector_pkg::INPUT_SCALAR: begin
          if (beat) begin
            mul_start <= 1'b1;
            state     <= ntm_vector_pkg::MULTIPLY;
          end
        end
        ntm_vector_pkg::MULTIPLY: begin
          if (mul_done) begin
            state <= ntm_vector_pkg::ENDER;
          end
        end
        ntm_vector_pkg::ENDER: begin
          // Hold here with the result while the buffer is full
          if (!full) begin
            if (job_end) begin
              done  <= 1'b1;
              state <= ntm_vector_pkg::STARTER;
            end else if (row_end) begin
              vec_idx <= vec_idx + 1'b1;
              sca_idx <= '0;
              state   <= ntm_vector_pkg::INPUT_VECTOR;
            end else begin
              sca_idx <= sca_idx + 1'b1;
              state   <= ntm_vector_pkg::INPUT_SCALAR;
            end
          end
        end
        default: begin
          state <= ntm_vector_pkg::STARTER;
        end
      endcase
    end
  end

  // Configuration, row element, scalar and product
  always_ff @(posedge CLK) begin
    if (state == ntm_vector_pkg::STARTER && start) begin
      cfg_q <= job_config;
    end
    if (state == ntm_vector_pkg::INPUT_VECTOR && beat) begin
      mul_a <= in_data;
    end
    if (state == ntm_vector_pkg::INPUT_SCALAR && beat) begin
      mul_b <= in_data;
    end
    if (state == ntm_vector_pkg::MULTIPLY && mul_done) begin
      prod_q <= mul_product;
    end
  end

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  ntm_scalar_multiplication u_scalar_mult (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .modulo  (mul_modulo),
    .done    (mul_done),
    .product (mul_product)
  );

endmodule

/* design/ntm_vector_multiplier_top.sv */
`timescale 1ns/1ns

module ntm_vector_multiplier_top (
  input  logic                                  CLK,
  input  logic                                  RST,
  // Job control
  input  logic                                  start,
  input  ntm_vector_pkg::mult_config_t          job_config,
  output logic                                  busy,
  output logic                                  done,
  // Operand stream
  input  logic                                  in_valid,
  input  logic [ntm_vector_pkg::DATA_WIDTH-1:0] in_data,
  output logic                                  in_ready,
  // Result stream
  output logic                                  out_valid,
  output ntm_vector_pkg::mult_result_t          out_result,
  input  logic                                  out_ready
);

  // Controller to buffer
  logic                         push;
  ntm_vector_pkg::mult_result_t push_result;
  logic                         full;

  // Producer, walks rows and drives the multiplier
  ntm_vector_multiplication u_ctrl (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .job_config  (job_config),
    .busy        (busy),
    .done        (done),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .push        (push),
    .push_result (push_result),
    .full        (full)
  );

  // Buffer against output back-pressure
  ntm_result_fifo u_fifo (
    .CLK         (CLK),
    .RST         (RST),
    .push        (push),
    .push_result (push_result),
    .full        (full),
    .out_valid   (out_valid),
    .out_result  (out_result),
    .out_ready   (out_ready)
  );

endmodule

/* testbench/ntm_vector_multiplier_tb.sv */
`timescale 1ns/1ns

module ntm_vector_multiplier_tb;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic                                  CLK;
  logic                                  RST;
  logic                                  start;
  ntm_vector_pkg::mult_config_t          job_config;
  logic                                  busy;
  logic                                  done;
  logic                                  in_valid;
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] in_data;
  logic                                  in_ready;
  logic                                  out_valid;
  ntm_vector_pkg::mult_result_t          out_result;
  logic                                  out_ready;

  // Jobs, operand beats and expected results from the data file
  ntm_vector_pkg::mult_config_t          jobs[$];
  int                                    job_end_beat[$];
  logic [ntm_vector_pkg::DATA_WIDTH-1:0] operands[$];
  bit                                    scalar_beat[$];
  ntm_vector_pkg::mult_result_t          expected[$];

  // Scoreboard
  int mismatches  = 0;
  int failures    = 0;
  int beats_taken = 0;
  int y_taken     = 0;
  int drained     = 0;
  int res_idx     = 0;
  int done_count  = 0;
  int cycle_count = 0;
  int limit       = 0;
  int peak_outstanding = 0;
  logic [31:0] lfsr_state = 32'h367eefa0;

  ntm_vector_multiplier_top ntm_vector_multiplier_top_inst (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .job_config (job_config),
    .busy       (busy),
    .done       (done),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_ready  (out_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Right shifting Galois LFSR
  function automatic logic [31:0] next_lfsr_state(input logic [31:0] s);
    next_lfsr_state = s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  task automatic take_random_bit(output logic bit_out);
    bit_out    = lfsr_state[0];
    lfsr_state = next_lfsr_state(lfsr_state);
  endtask

  // Run length is a floor plus four random bits weighted by step
  task automatic pick_run_length(input int floor_len, input int step, output int len);
    logic b;
    int k;
    len = floor_len;
    for (k = 0; k < 4; k++) begin
      take_random_bit(b);
      if (b) begin
        len += step << k;
      end
    end
  endtask

  // Record kinds J, V and E
  // A lone # token starts a comment line
  task automatic read_testdata();
    int fd;
    int n;
    int s;
    int l;
    int m;
    int x;
    int v;
    int i;
    int f0;
    int f1;
    int rows;
    int total;
    int chk;
    longint prod;
    string tok;
    string rest;
    ntm_vector_pkg::mult_config_t cfg;
    ntm_vector_pkg::mult_result_t entry;
    s     = 1;
    l     = 1;
    m     = 1;
    rows  = 0;
    total = 0;
    chk   = 0;
    fd = $fopen("testbench/ntm_vector_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the testdata file");
      failures++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        n = $fgets(rest, fd);
      end else if (tok == "J") begin
        n = $fscanf(fd, "%d %d %d", s, l, m);
        cfg.size   = s[ntm_vector_pkg::COUNT_WIDTH-1:0];
        cfg.length = l[ntm_vector_pkg::COUNT_WIDTH-1:0];
        cfg.modulo = m[ntm_vector_pkg::DATA_WIDTH-1:0];
        jobs.push_back(cfg);
        job_end_beat.push_back(total);
        rows = 0;
      end else if (tok == "V") begin
        // x first and then the row's scalars
        n = $fscanf(fd, "%d", x);
        operands.push_back(x[ntm_vector_pkg::DATA_WIDTH-1:0]);
        scalar_beat.push_back(1'b0);
        rows++;
        for (i = 0; i < l; i++) begin
          n = $fscanf(fd, "%d", v);
          operands.push_back(v[ntm_vector_pkg::DATA_WIDTH-1:0]);
          scalar_beat.push_back(1'b1);
          // Reference value (x * y) mod modulus
          prod          = (longint'(x) * longint'(v)) % longint'(m);
          entry.data    = prod[ntm_vector_pkg::DATA_WIDTH-1:0];
          entry.row_end = (i == l - 1);
          entry.last    = (i == l - 1) && (rows == s);
          expected.push_back(entry);
        end
        total += l + 1;
        job_end_beat[job_end_beat.size() - 1] = total;
      end else if (tok == "E") begin
        // File values must agree with the reference model
        for (i = 0; i < l; i++) begin
          n = $fscanf(fd, "%d %d %d", v, f0, f1);
          entry = (chk < expected.size()) ? expected[chk] : '0;
          if (entry.data != v[ntm_vector_pkg::DATA_WIDTH-1:0] ||
              entry.row_end != f0[0] || entry.last != f1[0]) begin
            $display("testdata result %0d does not match the product of its operands", chk);
            failures++;
          end
          chk++;
        end
      end else begin
        $display("unknown record %s in the testdata file", tok);
        failures++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_result();
    ntm_vector_pkg::mult_result_t exp_r;
    if (res_idx >= expected.size()) begin
      $display("extra result at %0t ns beyond the expected list", $time);
      failures++;
    end else begin
      exp_r = expected[res_idx];
      if (out_result.data != exp_r.data) begin
        $display("mismatch at %0t ns: out_result.data expected %0d got %0d",
                 $time, exp_r.data, out_result.data);
        mismatches++;
      end
      if (out_result.row_end != exp_r.row_end) begin
        $display("mismatch at %0t ns: out_result.row_end expected %0b got %0b",
                 $time, exp_r.row_end, out_result.row_end);
        mismatches++;
      end
      if (out_result.last != exp_r.last) begin
        $display("mismatch at %0t ns: out_result.last expected %0b got %0b",
                 $time, exp_r.last, out_result.last);
        mismatches++;
      end
    end
    res_idx++;
  endtask

  // New job started as soon as busy drops
  task automatic run_jobs();
    int j;
    int op;
    logic rdy;
    op = 0;
    for (j = 0; j < jobs.size(); j++) begin
      while (busy) begin
        @(negedge CLK);
      end
      job_config = jobs[j];
      start      = 1'b1;
      @(negedge CLK);
      start = 1'b0;
      while (op < job_end_beat[j]) begin
        in_valid = 1'b1;
        in_data  = operands[op];
        // in_ready follows state only and holds until the next rising edge
        rdy = in_ready;
        @(negedge CLK);
        if (rdy) begin
          if (scalar_beat[op]) begin
            y_taken <= y_taken + 1;
          end
          beats_taken <= beats_taken + 1;
          op++;
        end
      end
      in_valid = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Result side
  ////////////////////////////////////////////////////////////

  initial begin
    logic stalling;
    int   run_left;
    stalling = 1'b1;
    @(negedge RST);
    // First run is a stall long enough to fill the FIFO
    pick_run_length(128, 8, run_left);
    forever begin
      @(negedge CLK);
      // Ready runs twice as long as stall runs on average
      if (run_left == 0) begin
        stalling = !stalling;
        if (stalling) begin
          pick_run_length(128, 8, run_left);
        end else begin
          pick_run_length(256, 16, run_left);
        end
      end
      run_left--;
      out_ready = !stalling;
      if (out_valid && out_ready) begin
        check_result();
        drained <= drained + 1;
      end
      if (y_taken - drained > peak_outstanding) begin
        peak_outstanding = y_taken - drained;
      end
      // FIFO entries plus the one result held in the controller
      if (y_taken - drained > ntm_vector_pkg::FIFO_DEPTH + 1) begin
        $display("operands taken at %0t ns while the result FIFO was full", $time);
        failures++;
      end
      if (done) begin
        if (busy) begin
          $display("busy still high with done at %0t ns", $time);
          failures++;
        end
        if (done_count >= jobs.size()) begin
          $display("done pulsed at %0t ns with no job left", $time);
          failures++;
        end else if (beats_taken != job_end_beat[done_count]) begin
          $display("done at %0t ns before all operands of job %0d were taken",
                   $time, done_count);
          failures++;
        end
        done_count <= done_count + 1;
      end
    end
  end

  // Watchdog
  initial begin
    wait (limit > 0);
    while (cycle_count < limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d of %0d results drained",
             cycle_count, res_idx, expected.size());
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST        = 1'b1;
    start      = 1'b0;
    job_config = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b0;
    read_testdata();
    // Worst case per beat under back-pressure plus reset and drain
    limit = operands.size() * (ntm_vector_pkg::DATA_WIDTH + 3) * 4 + 200;
    repeat (16) @(negedge CLK);
    RST = 1'b0;
    // Quiet outputs before the first start
    repeat (3) begin
      @(negedge CLK);
      if (busy || done || in_ready || out_valid) begin
        $display("outputs active at %0t ns before any start", $time);
        failures++;
      end
    end
    run_jobs();
    while (drained < expected.size() || done_count < jobs.size()) begin
      @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    if (busy || out_valid) begin
      $display("DUT still busy or holding results after the last job");
      failures++;
    end
    if (peak_outstanding < ntm_vector_pkg::FIFO_DEPTH + 1) begin
      $display("back-pressure never filled the result FIFO");
      failures++;
    end
    $display("errors: %0d mismatches, %0d other failures, %0d of %0d results checked",
             mismatches, failures, res_idx, expected.size());
    if (mismatches == 0 && failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* testbench/ntm_vector_testdata.txt */
# J size length modulo
# V x followed by length scalars y
# E data row_end last for each result of the row
J 1 1 97
V 10 20
E 6 1 1
J 3 4 251
V 17 3 100 250 0
E 51 0 0 194 0 0 234 0 0 0 1 0
V 200 2 126 7 250
E 149 0 0 100 0 0 145 0 0 51 1 0
V 250 250 1 125 99
E 1 0 0 250 0 0 126 0 0 152 1 1
# Modulus just below 2 to the 16
J 3 1 65521
V 65520 65520
E 1 1 0
V 65000 60000
E 59038 1 0
V 300 400
E 54479 1 1
J 1 5 1009
V 1008 1 2 1008 500 777
E 1008 0 0 1007 0 0 1 0 0 509 0 0 232 1 1

/* project.f */
+incdir+include
design/ntm_vector_pkg.sv
design/ntm_scalar_multiplication.sv
design/ntm_result_fifo.sv
design/ntm_vector_multiplication.sv
design/ntm_vector_multiplier_top.sv
testbench/ntm_vector_multiplier_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ns -f project.f \
    --top-module ntm_vector_multiplier_tb --Mdir obj_dir -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -qx "=== PASS ===" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
